// ==== tb/dcache_testdata.txt ====
// op (0 load, 1 store)  size (0 byte, 1 half, 2 word)  address  store data  expected load data
// the expected column is ignored on stores
0 2 00000040 00000000 a5a50040
0 2 00000044 00000000 a5a50044
0 2 00000040 00000000 a5a50040
1 0 00000048 00000011 00000000
1 0 00000049 abcdef22 00000000
1 0 0000004a 00000033 00000000
1 0 0000004b 00000044 00000000
0 2 00000048 00000000 44332211
1 1 0000004c 0000beef 00000000
1 1 0000004e 1234dead 00000000
0 2 0000004c 00000000 deadbeef
0 1 0000004e 00000000 0000dead
0 0 0000004d 00000000 000000be
0 1 00000048 00000000 00002211
0 0 0000004b 00000000 00000044
1 2 00000144 12345678 00000000
1 2 00000248 cafef00d 00000000
0 2 00000048 00000000 44332211
0 2 00000144 00000000 12345678
0 2 00000248 00000000 cafef00d
0 2 0000004c 00000000 deadbeef
1 1 000003f2 00007777 00000000
0 2 000003f0 00000000 777703f0
0 2 0000034c 00000000 a5a5034c
0 2 00000040 00000000 a5a50040

// ==== build.f ====
rtl/dcache_pkg.sv
rtl/dcache_way_ram.sv
rtl/dcache_victim_lfsr.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  # synthesizable cache
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_way_ram.sv
      - rtl/dcache_victim_lfsr.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache.sv

  # testbench and bound checker
  - target: test
    files:
      - tb/dcache_checker.sv
      - tb/dcache_tb.sv

dependencies: {}

frozen: false

workspace: {}

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int          MEM_WORDS = 1024;
    localparam int          MAX_OPS   = 64;
    localparam int          OP_COLS   = 5;
    localparam logic [31:0] FILL_MASK = 32'hA5A5_0000;

    logic            clk = 1'b0;
    logic            rst_n;
    core_req_t       core_req_i;
    core_resp_t      core_resp_o;
    logic            busy_o;
    cache_bus_req_t  bus_req_o;
    cache_bus_resp_t bus_resp_i;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];
    logic [31:0] td [OP_COLS*MAX_OPS];
    bit          seen_line [logic [31:0]];
    logic [31:0] touched_q [$];
    logic [31:0] prev_line = 32'hFFFF_FFFF;
    int          cycles = 0;
    int          cycle_limit = 1000;
    int          bus_phase = 0;
    int          bus_beat;
    int          bus_base;
    logic        bus_write;

    dcache i_dcache (
        .clk         (clk),
        .rst_n       (rst_n),
        .core_req_i  (core_req_i),
        .core_resp_o (core_resp_o),
        .busy_o      (busy_o),
        .bus_req_o   (bus_req_o),
        .bus_resp_i  (bus_resp_i)
    );

    bind dcache dcache_checker i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (core_req_i),
        .resp_i     (core_resp_o),
        .busy_i     (busy_o),
        .bus_req_i  (bus_req_o),
        .bus_resp_i (bus_resp_i)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr >> 2);
    endfunction

    // byte and half stores merge into the shadow word
    task automatic apply_store(input logic [1:0] size, input logic [31:0] addr,
                               input logic [31:0] wdata);
        int idx;
        idx = word_index(addr);
        case (size)
            2'd0: shadow[idx][addr[1:0]*8 +: 8] = wdata[7:0];
            2'd1: shadow[idx][addr[1]*16 +: 16] = wdata[15:0];
            default: shadow[idx] = wdata;
        endcase
    endtask

    task automatic run_op(input logic wr, input logic [1:0] size, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] expected);
        logic [31:0] line;
        logic        first;
        int          lat;
        line  = {addr[31:4], 4'h0};
        first = !seen_line.exists(line);
        while (busy_o) begin
            @(posedge clk);
            #1;
        end
        core_req_i = '{valid: 1'b1, write: wr, size: mem_size_e'(size),
                       addr: cache_addr_t'(addr), wdata: wdata};
        @(posedge clk);
        #1;
        core_req_i.valid = 1'b0;
        lat = 0;
        while (!core_resp_o.valid) begin
            @(posedge clk);
            #1;
            lat++;
        end
        // a new line must miss, the line just used must hit
        if (first) begin
            assert (lat > 2) else begin
                $display("[ERROR] %0t: line %h answered after %0d cycles on first access",
                         $time, line, lat);
                abort_run();
            end
        end else if (line == prev_line) begin
            assert (lat == 2) else begin
                $display("[ERROR] %0t: core_resp_o.valid latency got %0d, expected 2",
                         $time, lat);
                abort_run();
            end
        end
        if (wr) begin
            apply_store(size, addr, wdata);
        end else begin
            assert (core_resp_o.rdata === expected) else begin
                $display("[ERROR] %0t: core_resp_o.rdata at %h got %h, expected %h",
                         $time, addr, core_resp_o.rdata, expected);
                abort_run();
            end
        end
        if (first) begin
            seen_line[line] = 1'b1;
            touched_q.push_back(line);
        end
        prev_line = line;
    endtask

    // burst memory, ready after one wait cycle, beats back to back
    always begin
        @(posedge clk);
        #1;
        bus_resp_i.ready     = 1'b0;
        bus_resp_i.data_ok   = 1'b0;
        bus_resp_i.data_last = 1'b0;
        bus_resp_i.r_data    = '0;
        case (bus_phase)
            0: begin
                if (rst_n && bus_req_o.valid) begin
                    bus_phase = 1;
                end
            end
            1: begin
                assert (bus_req_o.addr < MEM_WORDS*4) else begin
                    $display("bus address %h lies outside the memory model", bus_req_o.addr);
                    abort_run();
                end
                bus_base         = word_index(bus_req_o.addr);
                bus_write        = bus_req_o.write;
                bus_beat         = 0;
                bus_resp_i.ready = 1'b1;
                bus_phase        = 2;
            end
            default: begin
                if (bus_write) begin
                    mem[bus_base + bus_beat] = bus_req_o.w_data;
                end else begin
                    bus_resp_i.r_data = mem[bus_base + bus_beat];
                end
                bus_resp_i.data_ok   = 1'b1;
                bus_resp_i.data_last = (bus_beat == LINE_WORDS - 1);
                bus_beat++;
                if (bus_beat == LINE_WORDS) begin
                    bus_phase = 0;
                end
            end
        endcase
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $fatal(1, "cycle limit reached");
        end else if (i_dcache.i_checker.fail_cnt != 0) begin
            $display("a bound checker assertion failed");
            $display("Test failures found");
            $fatal(1, "checker failure");
        end
    end

    initial begin
        int n_ops;
        rst_n      = 1'b0;
        core_req_i = '0;
        bus_resp_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = 32'(i * 4) ^ FILL_MASK;
            shadow[i] = mem[i];
        end
        for (int i = 0; i < OP_COLS*MAX_OPS; i++) begin
            td[i] = '1;
        end
        $readmemh("tb/dcache_testdata.txt", td);
        n_ops = 0;
        while (n_ops < MAX_OPS && td[OP_COLS*n_ops] != 32'hFFFF_FFFF) begin
            n_ops++;
        end
        cycle_limit = 200 * n_ops;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (n_ops > 0) else begin
            $display("no operations read from tb/dcache_testdata.txt");
            abort_run();
        end
        assert (!busy_o && !bus_req_o.valid && !core_resp_o.valid) else begin
            $display("[ERROR] %0t: busy_o=%b bus_req_o.valid=%b core_resp_o.valid=%b, expected 0",
                     $time, busy_o, bus_req_o.valid, core_resp_o.valid);
            abort_run();
        end
        for (int n = 0; n < n_ops; n++) begin
            run_op(td[OP_COLS*n][0], td[OP_COLS*n+1][1:0], td[OP_COLS*n+2],
                   td[OP_COLS*n+3], td[OP_COLS*n+4]);
        end
        // read back every touched line against the shadow copy
        foreach (touched_q[t]) begin
            for (int k = 0; k < LINE_WORDS; k++) begin
                run_op(1'b0, 2'd2, touched_q[t] + 4*k, 32'h0,
                       shadow[word_index(touched_q[t] + 4*k)]);
            end
        end
        if (i_dcache.i_checker.fail_cnt == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("a bound checker assertion failed");
            $display("Test failures found");
            $fatal(1, "checker failure");
        end
    end

endmodule

`default_nettype wire

// ==== tb/dcache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_checker
    import dcache_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire core_req_t       req_i,
    input  wire core_resp_t      resp_i,
    input  wire logic            busy_i,
    input  wire cache_bus_req_t  bus_req_i,
    input  wire cache_bus_resp_t bus_resp_i
);

    int fail_cnt = 0;

    // address phase held until the memory takes it
    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req_i.valid && !bus_resp_i.ready |=>
            bus_req_i.valid && $stable(bus_req_i.addr) && $stable(bus_req_i.write))
        else begin
            $error("bus address phase changed before ready");
            fail_cnt++;
        end

    resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resp_i.valid |=> !resp_i.valid)
        else begin
            $error("core response valid longer than one cycle");
            fail_cnt++;
        end

    // busy from the accepting edge up to the response edge
    busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
        req_i.valid && !busy_i |=> busy_i)
        else begin
            $error("busy not raised after an accepted request");
            fail_cnt++;
        end

    busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy_i) |-> resp_i.valid)
        else begin
            $error("busy dropped without a response");
            fail_cnt++;
        end

    idle_bus: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_i |-> !bus_req_i.valid)
        else begin
            $error("bus request while the cache is idle");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache
    import dcache_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire core_req_t       core_req_i,
    output core_resp_t           core_resp_o,
    output logic                 busy_o,
    output cache_bus_req_t       bus_req_o,
    input  wire cache_bus_resp_t bus_resp_i
);

    logic [WAY_CNT-1:0][INDEX_W-1:0]  ram_r_index;
    logic [WAY_CNT-1:0][OFFSET_W-1:0] ram_r_offset;
    logic [WAY_CNT-1:0][INDEX_W-1:0]  ram_w_index;
    logic [WAY_CNT-1:0][OFFSET_W-1:0] ram_w_offset;
    logic [WAY_CNT-1:0][3:0]          ram_data_we;
    logic [WAY_CNT-1:0]               ram_tag_we;
    logic [WAY_CNT-1:0][31:0]         ram_wdata;
    tag_entry_t [WAY_CNT-1:0]         ram_wtag;
    logic [WAY_CNT-1:0][31:0]         ram_rdata;
    tag_entry_t [WAY_CNT-1:0]         ram_rtag;

    logic                             lfsr_advance;
    logic [WAY_W-1:0]                 victim;

    dcache_ctrl i_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_i     (core_req_i),
        .core_resp_o    (core_resp_o),
        .busy_o         (busy_o),
        .bus_req_o      (bus_req_o),
        .bus_resp_i     (bus_resp_i),
        .ram_r_index_o  (ram_r_index),
        .ram_r_offset_o (ram_r_offset),
        .ram_w_index_o  (ram_w_index),
        .ram_w_offset_o (ram_w_offset),
        .ram_data_we_o  (ram_data_we),
        .ram_tag_we_o   (ram_tag_we),
        .ram_wdata_o    (ram_wdata),
        .ram_wtag_o     (ram_wtag),
        .ram_rdata_i    (ram_rdata),
        .ram_rtag_i     (ram_rtag),
        .lfsr_advance_o (lfsr_advance),
        .victim_i       (victim)
    );

    // one tag and data store per way
    for (genvar w = 0; w < WAY_CNT; w++) begin : g_way
        dcache_way_ram i_way_ram (
            .clk        (clk),
            .rst_n      (rst_n),
            .r_index_i  (ram_r_index[w]),
            .r_offset_i (ram_r_offset[w]),
            .w_index_i  (ram_w_index[w]),
            .w_offset_i (ram_w_offset[w]),
            .data_we_i  (ram_data_we[w]),
            .tag_we_i   (ram_tag_we[w]),
            .data_i     (ram_wdata[w]),
            .tag_i      (ram_wtag[w]),
            .data_o     (ram_rdata[w]),
            .tag_o      (ram_rtag[w])
        );
    end

    dcache_victim_lfsr i_lfsr (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance_i (lfsr_advance),
        .victim_o  (victim)
    );

endmodule

`default_nettype wire

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire core_req_t                           core_req_i,
    output core_resp_t                               core_resp_o,
    output logic                                     busy_o,
    output cache_bus_req_t                           bus_req_o,
    input  wire cache_bus_resp_t                     bus_resp_i,
    output logic [WAY_CNT-1:0][INDEX_W-1:0]          ram_r_index_o,
    output logic [WAY_CNT-1:0][OFFSET_W-1:0]         ram_r_offset_o,
    output logic [WAY_CNT-1:0][INDEX_W-1:0]          ram_w_index_o,
    output logic [WAY_CNT-1:0][OFFSET_W-1:0]         ram_w_offset_o,
    output logic [WAY_CNT-1:0][3:0]                  ram_data_we_o,
    output logic [WAY_CNT-1:0]                       ram_tag_we_o,
    output logic [WAY_CNT-1:0][31:0]                 ram_wdata_o,
    output tag_entry_t [WAY_CNT-1:0]                 ram_wtag_o,
    input  wire logic [WAY_CNT-1:0][31:0]            ram_rdata_i,
    input  wire tag_entry_t [WAY_CNT-1:0]            ram_rtag_i,
    output logic                                     lfsr_advance_o,
    input  wire logic [WAY_W-1:0]                    victim_i
);

    typedef enum logic [2:0] {
        IDLE, REPLAY, LOOKUP, WB_ADDR, WB_DATA, RF_ADDR, RF_DATA
    } state_e;

    state_e                      state_q, state_d;
    core_req_t                   req_q;
    logic                        resp_valid_q;
    logic [31:0]                 resp_rdata_q;
    logic [WAY_W-1:0]            victim_q;
    logic [TAG_W-1:0]            wb_tag_q;
    // read counter and its delayed copy, top bit set when done
    logic [OFFSET_W:0]           rd_cnt_q, rd_cnt_d1_q;
    logic [OFFSET_W-1:0]         beat_q;
    logic [LINE_WORDS-1:0][31:0] wb_buf_q;

    logic [WAY_CNT-1:0]          match, victim_onehot, way_sel;
    logic                        hit, tag_we;
    logic [31:0]                 hit_data, load_shift, load_data, store_data, w_data, wb_word;
    logic [3:0]                  strobe, data_we;
    logic [OFFSET_W-1:0]         r_offset, w_offset;
    tag_entry_t                  w_tag;
    cache_addr_t                 line_addr;

    always_comb begin
        hit_data = '0;
        for (int w = 0; w < WAY_CNT; w++) begin
            match[w] = ram_rtag_i[w].valid && (ram_rtag_i[w].tag == req_q.addr.tag);
            if (match[w]) begin
                hit_data |= ram_rdata_i[w];
            end
        end
    end
    assign hit = |match;

    // load extraction and store alignment
    assign load_shift = hit_data >> {req_q.addr.byte_off, 3'b000};
    assign store_data = req_q.wdata << {req_q.addr.byte_off, 3'b000};
    always_comb begin
        case (req_q.size)
            SIZE_BYTE: begin
                load_data = {24'd0, load_shift[7:0]};
                strobe    = 4'b0001 << req_q.addr.byte_off;
            end
            SIZE_HALF: begin
                load_data = {16'd0, load_shift[15:0]};
                strobe    = 4'b0011 << {req_q.addr.byte_off[1], 1'b0};
            end
            default: begin
                load_data = hit_data;
                strobe    = 4'b1111;
            end
        endcase
    end

    always_comb begin
        victim_onehot           = '0;
        victim_onehot[victim_q] = 1'b1;
    end
    assign way_sel = (state_q == LOOKUP) ? match : victim_onehot;

    always_comb begin
        state_d        = state_q;
        lfsr_advance_o = 1'b0;
        data_we        = 4'b0000;
        tag_we         = 1'b0;
        w_offset       = req_q.addr.offset;
        w_data         = store_data;
        w_tag          = '{valid: 1'b1, dirty: 1'b1, tag: req_q.addr.tag};
        case (state_q)
            IDLE: begin
                if (core_req_i.valid) begin
                    state_d = REPLAY;
                end
            end
            // set read from the latched request
            REPLAY: state_d = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    if (req_q.write) begin
                        data_we = strobe;
                        tag_we  = 1'b1;
                    end
                    state_d = IDLE;
                end else begin
                    lfsr_advance_o = 1'b1;
                    if (ram_rtag_i[victim_i].valid && ram_rtag_i[victim_i].dirty) begin
                        state_d = WB_ADDR;
                    end else begin
                        state_d = RF_ADDR;
                    end
                end
            end
            WB_ADDR: begin
                if (bus_resp_i.ready) begin
                    state_d = WB_DATA;
                end
            end
            WB_DATA: begin
                if (bus_resp_i.data_ok && bus_resp_i.data_last) begin
                    state_d = RF_ADDR;
                end
            end
            RF_ADDR: begin
                if (bus_resp_i.ready) begin
                    state_d = RF_DATA;
                end
            end
            RF_DATA: begin
                w_offset    = beat_q;
                w_data      = bus_resp_i.r_data;
                w_tag.dirty = 1'b0;
                if (bus_resp_i.data_ok) begin
                    data_we = 4'b1111;
                    if (bus_resp_i.data_last) begin
                        tag_we  = 1'b1;
                        state_d = REPLAY;
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            resp_valid_q <= 1'b0;
            beat_q       <= '0;
        end else begin
            state_q      <= state_d;
            resp_valid_q <= (state_q == LOOKUP) && hit;
            if (state_q == WB_ADDR || state_q == RF_ADDR) begin
                beat_q <= '0;
            end else if ((state_q == WB_DATA || state_q == RF_DATA) && bus_resp_i.data_ok) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && core_req_i.valid) begin
            req_q <= core_req_i;
        end
        if (state_q == LOOKUP) begin
            resp_rdata_q <= load_data;
            victim_q     <= victim_i;
            wb_tag_q     <= ram_rtag_i[victim_i].tag;
        end
    end

    // writeback read runs one word ahead of the bus beats
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_cnt_q    <= {1'b1, {OFFSET_W{1'b0}}};
            rd_cnt_d1_q <= {1'b1, {OFFSET_W{1'b0}}};
        end else begin
            rd_cnt_d1_q <= rd_cnt_q;
            if (state_q == LOOKUP && state_d == WB_ADDR) begin
                rd_cnt_q <= '0;
            end else if (!rd_cnt_q[OFFSET_W]) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rd_cnt_d1_q[OFFSET_W]) begin
            wb_buf_q[rd_cnt_d1_q[OFFSET_W-1:0]] <= ram_rdata_i[victim_q];
        end
    end

    // bypass when the beat word is still on the ram output
    assign wb_word = (!rd_cnt_d1_q[OFFSET_W] && rd_cnt_d1_q[OFFSET_W-1:0] == beat_q) ?
                     ram_rdata_i[victim_q] : wb_buf_q[beat_q];

    always_comb begin
        line_addr          = req_q.addr;
        line_addr.offset   = '0;
        line_addr.byte_off = '0;
        if (state_q == WB_ADDR || state_q == WB_DATA) begin
            line_addr.tag = wb_tag_q;
        end
    end

    assign bus_req_o.valid  = (state_q == WB_ADDR) || (state_q == RF_ADDR);
    assign bus_req_o.write  = (state_q == WB_ADDR) || (state_q == WB_DATA);
    assign bus_req_o.addr   = line_addr;
    assign bus_req_o.w_data = wb_word;

    assign r_offset = (state_q == WB_ADDR || state_q == WB_DATA) ?
                      rd_cnt_q[OFFSET_W-1:0] : req_q.addr.offset;

    assign ram_r_index_o  = {WAY_CNT{req_q.addr.index}};
    assign ram_r_offset_o = {WAY_CNT{r_offset}};
    assign ram_w_index_o  = {WAY_CNT{req_q.addr.index}};
    assign ram_w_offset_o = {WAY_CNT{w_offset}};
    assign ram_wdata_o    = {WAY_CNT{w_data}};
    assign ram_wtag_o     = {WAY_CNT{w_tag}};
    always_comb begin
        for (int w = 0; w < WAY_CNT; w++) begin
            ram_data_we_o[w] = data_we & {4{way_sel[w]}};
            ram_tag_we_o[w]  = tag_we & way_sel[w];
        end
    end

    assign core_resp_o.valid = resp_valid_q;
    assign core_resp_o.rdata = resp_rdata_q;
    assign busy_o            = (state_q != IDLE);

endmodule

`default_nettype wire

// ==== rtl/dcache_victim_lfsr.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_victim_lfsr
    import dcache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        advance_i,
    output logic [WAY_W-1:0] victim_o
);

    logic [7:0] lfsr_q;

    // galois step, one per miss
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr_q <= LFSR_SEED;
        end else if (advance_i) begin
            lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 8'h00);
        end
    end

    assign victim_o = lfsr_q[WAY_W-1:0];

endmodule

`default_nettype wire

// ==== rtl/dcache_way_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_way_ram
    import dcache_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [INDEX_W-1:0]  r_index_i,
    input  wire logic [OFFSET_W-1:0] r_offset_i,
    input  wire logic [INDEX_W-1:0]  w_index_i,
    input  wire logic [OFFSET_W-1:0] w_offset_i,
    input  wire logic [3:0]          data_we_i,
    input  wire logic                tag_we_i,
    input  wire logic [31:0]         data_i,
    input  wire tag_entry_t          tag_i,
    output logic [31:0]              data_o,
    output tag_entry_t               tag_o
);

    // valid bits in flops, dirty, tag and data in arrays
    logic [SET_CNT-1:0] valid_q;
    logic               dirty_mem [SET_CNT];
    logic [TAG_W-1:0]   tag_mem [SET_CNT];
    logic [31:0]        data_mem [SET_CNT*LINE_WORDS];

    logic               valid_rd_q;
    logic               dirty_rd_q;
    logic [TAG_W-1:0]   tag_rd_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (tag_we_i) begin
            valid_q[w_index_i] <= tag_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            dirty_mem[w_index_i] <= tag_i.dirty;
            tag_mem[w_index_i]   <= tag_i.tag;
        end
        for (int b = 0; b < 4; b++) begin
            if (data_we_i[b]) begin
                data_mem[{w_index_i, w_offset_i}][b*8 +: 8] <= data_i[b*8 +: 8];
            end
        end
    end

    // registered read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        valid_rd_q <= valid_q[r_index_i];
        dirty_rd_q <= dirty_mem[r_index_i];
        tag_rd_q   <= tag_mem[r_index_i];
        data_o     <= data_mem[{r_index_i, r_offset_i}];
    end

    assign tag_o = '{valid: valid_rd_q, dirty: dirty_rd_q, tag: tag_rd_q};

endmodule

`default_nettype wire

// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int WAY_CNT    = 2;
    localparam int WAY_W      = $clog2(WAY_CNT);
    localparam int SET_CNT    = 16;
    localparam int LINE_WORDS = 4;
    localparam int INDEX_W    = $clog2(SET_CNT);
    localparam int OFFSET_W   = $clog2(LINE_WORDS);
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W - 2;

    // victim lfsr, x^8 + x^6 + x^5 + x^4 + 1 in right-shift form
    localparam logic [7:0] LFSR_TAPS = 8'hB8;
    localparam logic [7:0] LFSR_SEED = 8'hE1;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [1:0]          byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        mem_size_e   size;
        cache_addr_t addr;
        logic [31:0] wdata;
    } core_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } core_resp_t;

    // address phase fields plus write data of the current beat
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] w_data;
    } cache_bus_req_t;

    typedef struct packed {
        logic        ready;
        logic        data_ok;
        logic        data_last;
        logic [31:0] r_data;
    } cache_bus_resp_t;

endpackage

`default_nettype wire
